//--- design/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data and address width
`define WORD_SIZE 16

// General registers
`define NUM_REGS 4

// Cycles a memory request stays on the port
`define MEM_LATENCY 2

// Opcode 11 is unassigned, so this word decodes as a bubble
`define NOP_WORD 16'hb000

`endif

//--- design/cpu_pkg.sv
`default_nettype none
`include "cpu_params.svh"

package cpu_pkg;

	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_ADI   = 4'd4,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_RTYPE = 4'd15
	} opcode_e;

	// Function field of RTYPE
	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_PASS_A
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE  = 2'd0,
		FWD_EXMEM = 2'd1,
		FWD_MEMWB = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    use_imm;
		logic    is_branch;
		logic    branch_on_equal;
		logic    is_jump;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		// 1 picks rd, 0 picks rt
		logic    dest_sel;
		logic    is_wwd;
		logic    is_halt;
		logic    valid;
	} ctrl_t;

	typedef struct packed {
		logic [`WORD_SIZE-1:0] instr;
		logic [`WORD_SIZE-1:0] pc;
	} ifid_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [1:0]            rs;
		logic [1:0]            rt;
		logic [1:0]            dest;
		logic [`WORD_SIZE-1:0] rs_data;
		logic [`WORD_SIZE-1:0] rt_data;
		logic [`WORD_SIZE-1:0] imm;
		logic [`WORD_SIZE-1:0] br_target;
		logic [`WORD_SIZE-1:0] jmp_target;
	} idex_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [1:0]            dest;
		logic [`WORD_SIZE-1:0] alu_out;
		logic [`WORD_SIZE-1:0] st_data;
	} exmem_t;

	typedef struct packed {
		ctrl_t                 ctrl;
		logic [1:0]            dest;
		logic [`WORD_SIZE-1:0] alu_out;
		logic [`WORD_SIZE-1:0] mem_data;
	} memwb_t;

endpackage

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module control_unit (
	input  wire [`WORD_SIZE-1:0] i_instr,
	output cpu_pkg::ctrl_t       o_ctrl
);
	import cpu_pkg::*;

	opcode_e opcode;
	func_e   func;

	assign opcode = opcode_e'(i_instr[15:12]);
	assign func   = func_e'(i_instr[5:0]);

	always_comb begin
		o_ctrl        = '0;
		o_ctrl.alu_op = ALU_ADD;
		case (opcode)
			OP_ADI, OP_LWD, OP_SWD: begin
				// Address and ADI sum share the adder
				o_ctrl.use_imm   = 1'b1;
				o_ctrl.mem_read  = (opcode == OP_LWD);
				o_ctrl.mem_write = (opcode == OP_SWD);
				o_ctrl.reg_write = (opcode != OP_SWD);
				o_ctrl.valid     = 1'b1;
			end
			OP_BNE, OP_BEQ: begin
				o_ctrl.alu_op          = ALU_SUB;
				o_ctrl.is_branch       = 1'b1;
				o_ctrl.branch_on_equal = (opcode == OP_BEQ);
				o_ctrl.valid           = 1'b1;
			end
			OP_JMP: begin
				o_ctrl.is_jump = 1'b1;
				o_ctrl.valid   = 1'b1;
			end
			OP_RTYPE: begin
				o_ctrl.valid = 1'b1;
				case (func)
					FN_ADD: o_ctrl.alu_op = ALU_ADD;
					FN_SUB: o_ctrl.alu_op = ALU_SUB;
					FN_AND: o_ctrl.alu_op = ALU_AND;
					FN_ORR: o_ctrl.alu_op = ALU_OR;
					FN_WWD: o_ctrl.alu_op = ALU_PASS_A;
					FN_HLT: o_ctrl.alu_op = ALU_PASS_A;
					default: o_ctrl.valid = 1'b0;
				endcase
				o_ctrl.is_wwd    = (func == FN_WWD);
				o_ctrl.is_halt   = (func == FN_HLT);
				o_ctrl.reg_write = o_ctrl.valid && !o_ctrl.is_wwd && !o_ctrl.is_halt;
				o_ctrl.dest_sel  = 1'b1;
			end
			default: o_ctrl.valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module register_file (
	input  wire                   clk,
	input  wire                   reset_n,
	input  wire  [1:0]            i_rs,
	input  wire  [1:0]            i_rt,
	input  wire  [1:0]            i_rd,
	input  wire                   i_we,
	input  wire  [`WORD_SIZE-1:0] i_wdata,
	output logic [`WORD_SIZE-1:0] o_rs_data,
	output logic [`WORD_SIZE-1:0] o_rt_data
);
	logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset_n) begin
			for (int i = 0; i < `NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (i_we) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// Bypass the write-back value to a same-cycle reader
	assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
	assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module alu (
	input  wire cpu_pkg::alu_op_e i_op,
	input  wire  [`WORD_SIZE-1:0] i_a,
	input  wire  [`WORD_SIZE-1:0] i_b,
	output logic [`WORD_SIZE-1:0] o_result,
	output logic                  o_equal
);
	import cpu_pkg::*;

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_AND: o_result = i_a & i_b;
			ALU_OR:  o_result = i_a | i_b;
			default: o_result = i_a;
		endcase
	end

	// Branch condition for BEQ and BNE
	assign o_equal = (i_a == i_b);

endmodule

`default_nettype wire

//--- design/hazard_forward.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_forward (
	input  wire cpu_pkg::ifid_t  i_ifid,
	input  wire cpu_pkg::idex_t  i_idex,
	input  wire cpu_pkg::exmem_t i_exmem,
	input  wire cpu_pkg::memwb_t i_memwb,
	output logic                 o_stall,
	output cpu_pkg::fwd_sel_e    o_fwd_a,
	output cpu_pkg::fwd_sel_e    o_fwd_b
);
	import cpu_pkg::*;

	opcode_e    id_op;
	logic [1:0] id_rs;
	logic [1:0] id_rt;
	logic       uses_rs;
	logic       uses_rt;

	// Youngest writer wins
	function automatic fwd_sel_e pick(input logic [1:0] src, input exmem_t mem,
			input memwb_t wb);
		if (mem.ctrl.reg_write && mem.dest == src)
			return FWD_EXMEM;
		if (wb.ctrl.reg_write && wb.dest == src)
			return FWD_MEMWB;
		return FWD_NONE;
	endfunction

	assign id_op = opcode_e'(i_ifid.instr[15:12]);
	assign id_rs = i_ifid.instr[11:10];
	assign id_rt = i_ifid.instr[9:8];

	always_comb begin
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (id_op)
			OP_ADI, OP_LWD: uses_rs = 1'b1;
			OP_RTYPE, OP_SWD, OP_BNE, OP_BEQ: begin
				uses_rs = 1'b1;
				uses_rt = 1'b1;
			end
			default: uses_rs = 1'b0;
		endcase
	end

	// Load result arrives too late for the next instruction
	assign o_stall = i_idex.ctrl.mem_read &&
		((uses_rs && id_rs == i_idex.dest) || (uses_rt && id_rt == i_idex.dest));

	assign o_fwd_a = pick(i_idex.rs, i_exmem, i_memwb);
	assign o_fwd_b = pick(i_idex.rt, i_exmem, i_memwb);

endmodule

`default_nettype wire

//--- design/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_core (
	input  wire                   clk,
	input  wire                   reset_n,
	output logic                  o_i_read,
	output logic [`WORD_SIZE-1:0] o_i_addr,
	input  wire  [`WORD_SIZE-1:0] i_i_data,
	output logic                  o_d_read,
	output logic                  o_d_write,
	output logic [`WORD_SIZE-1:0] o_d_addr,
	output logic [`WORD_SIZE-1:0] o_d_wdata,
	input  wire  [`WORD_SIZE-1:0] i_d_rdata,
	output logic [`WORD_SIZE-1:0] o_num_inst,
	output logic [`WORD_SIZE-1:0] o_output_port,
	output logic                  o_halted
);
	import cpu_pkg::*;

	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`MEM_LATENCY - 1);

	logic [`WORD_SIZE-1:0] pc;
	logic                  fetch_on;
	logic                  halt_seen;
	logic [CNT_W-1:0]      i_cnt;
	logic [CNT_W-1:0]      d_cnt;
	logic                  i_done;
	logic                  d_req;
	logic                  d_done;
	logic                  d_wait;

	ifid_t  ifid;
	idex_t  idex;
	exmem_t exmem;
	memwb_t memwb;

	ctrl_t                 id_ctrl;
	logic [`WORD_SIZE-1:0] rs_data;
	logic [`WORD_SIZE-1:0] rt_data;
	logic [`WORD_SIZE-1:0] id_imm;
	logic [1:0]            id_dest;
	logic                  stall;
	logic                  halt_take;
	fwd_sel_e              fwd_a;
	fwd_sel_e              fwd_b;
	logic [`WORD_SIZE-1:0] ex_a;
	logic [`WORD_SIZE-1:0] ex_fwd_b;
	logic [`WORD_SIZE-1:0] ex_b;
	logic [`WORD_SIZE-1:0] alu_out;
	logic                  ex_equal;
	logic                  redirect;
	logic [`WORD_SIZE-1:0] redirect_pc;
	logic [`WORD_SIZE-1:0] wb_data;

	function automatic logic [`WORD_SIZE-1:0] fwd_value(input fwd_sel_e sel,
			input logic [`WORD_SIZE-1:0] reg_val, input logic [`WORD_SIZE-1:0] mem_val,
			input logic [`WORD_SIZE-1:0] wb_val);
		case (sel)
			FWD_EXMEM: return mem_val;
			FWD_MEMWB: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// Memory ports and their wait counters
	assign o_i_read  = fetch_on;
	assign o_i_addr  = pc;
	assign i_done    = fetch_on && (i_cnt == CNT_LAST);
	assign o_d_read  = exmem.ctrl.mem_read;
	assign o_d_write = exmem.ctrl.mem_write;
	assign o_d_addr  = exmem.alu_out;
	assign o_d_wdata = exmem.st_data;
	assign d_req     = o_d_read || o_d_write;
	assign d_done    = d_req && (d_cnt == CNT_LAST);
	// Whole pipeline freezes while this is high
	assign d_wait    = d_req && !d_done;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			d_cnt <= '0;
		end else if (d_done) begin
			d_cnt <= '0;
		end else if (d_req) begin
			d_cnt <= d_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_n) begin
			i_cnt <= '0;
		end else if (!d_wait) begin
			if (redirect || !fetch_on)
				i_cnt <= '0;
			else if (i_cnt != CNT_LAST)
				i_cnt <= i_cnt + 1'b1;
			else if (!stall)
				i_cnt <= '0;
		end
	end

	// IF
	always_ff @(posedge clk) begin
		if (reset_n) begin
			pc        <= '0;
			fetch_on  <= 1'b0;
			halt_seen <= 1'b0;
			ifid      <= '{instr: `NOP_WORD, pc: '0};
		end else if (!d_wait) begin
			fetch_on <= !(halt_seen || halt_take);
			if (halt_take)
				halt_seen <= 1'b1;
			if (redirect)
				pc <= redirect_pc;
			else if (i_done && !stall)
				pc <= pc + 1'b1;
			if (redirect || halt_take) begin
				ifid.instr <= `NOP_WORD;
			end else if (!stall) begin
				ifid.instr <= i_done ? i_i_data : `NOP_WORD;
				ifid.pc    <= pc;
			end
		end
	end

	// ID
	control_unit u_control (
		.i_instr (ifid.instr),
		.o_ctrl  (id_ctrl)
	);

	register_file u_regs (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_rs      (ifid.instr[11:10]),
		.i_rt      (ifid.instr[9:8]),
		.i_rd      (memwb.dest),
		.i_we      (memwb.ctrl.reg_write && !d_wait),
		.i_wdata   (wb_data),
		.o_rs_data (rs_data),
		.o_rt_data (rt_data)
	);

	hazard_forward u_hazard (
		.i_ifid  (ifid),
		.i_idex  (idex),
		.i_exmem (exmem),
		.i_memwb (memwb),
		.o_stall (stall),
		.o_fwd_a (fwd_a),
		.o_fwd_b (fwd_b)
	);

	assign id_imm    = {{(`WORD_SIZE-8){ifid.instr[7]}}, ifid.instr[7:0]};
	assign id_dest   = id_ctrl.dest_sel ? ifid.instr[7:6] : ifid.instr[9:8];
	// HLT leaving ID is certain to retire
	assign halt_take = id_ctrl.valid && id_ctrl.is_halt && !redirect && !stall;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			idex.ctrl <= '0;
		end else if (!d_wait) begin
			if (redirect || stall)
				idex.ctrl <= '0;
			else
				idex.ctrl <= id_ctrl;
			idex.rs         <= ifid.instr[11:10];
			idex.rt         <= ifid.instr[9:8];
			idex.dest       <= id_dest;
			idex.rs_data    <= rs_data;
			idex.rt_data    <= rt_data;
			idex.imm        <= id_imm;
			idex.br_target  <= ifid.pc + 1'b1 + id_imm;
			idex.jmp_target <= {ifid.pc[`WORD_SIZE-1:12], ifid.instr[11:0]};
		end
	end

	// EX
	assign ex_a     = fwd_value(fwd_a, idex.rs_data, exmem.alu_out, wb_data);
	assign ex_fwd_b = fwd_value(fwd_b, idex.rt_data, exmem.alu_out, wb_data);
	assign ex_b     = idex.ctrl.use_imm ? idex.imm : ex_fwd_b;

	alu u_alu (
		.i_op     (idex.ctrl.alu_op),
		.i_a      (ex_a),
		.i_b      (ex_b),
		.o_result (alu_out),
		.o_equal  (ex_equal)
	);

	// Not-taken prediction, so only a taken transfer redirects
	assign redirect = idex.ctrl.valid && (idex.ctrl.is_jump ||
		(idex.ctrl.is_branch && (ex_equal == idex.ctrl.branch_on_equal)));
	assign redirect_pc = idex.ctrl.is_jump ? idex.jmp_target : idex.br_target;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			exmem.ctrl <= '0;
		end else if (!d_wait) begin
			exmem.ctrl    <= idex.ctrl;
			exmem.dest    <= idex.dest;
			exmem.alu_out <= alu_out;
			exmem.st_data <= ex_fwd_b;
		end
	end

	// MEM
	always_ff @(posedge clk) begin
		if (reset_n) begin
			memwb.ctrl <= '0;
		end else if (!d_wait) begin
			memwb.ctrl     <= exmem.ctrl;
			memwb.dest     <= exmem.dest;
			memwb.alu_out  <= exmem.alu_out;
			memwb.mem_data <= i_d_rdata;
		end
	end

	// WB
	assign wb_data = memwb.ctrl.mem_read ? memwb.mem_data : memwb.alu_out;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			o_num_inst    <= '0;
			o_output_port <= '0;
			o_halted      <= 1'b0;
		end else if (!d_wait && memwb.ctrl.valid) begin
			o_num_inst <= o_num_inst + 1'b1;
			if (memwb.ctrl.is_wwd)
				o_output_port <= memwb.alu_out;
			if (memwb.ctrl.is_halt)
				o_halted <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- tb/cpu_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module cpu_checker (
	input wire                  clk,
	input wire                  reset_n,
	input wire                  i_i_read,
	input wire [`WORD_SIZE-1:0] i_i_addr,
	input wire                  i_fetch_done,
	input wire                  i_redirect,
	input wire                  i_d_read,
	input wire                  i_d_write,
	input wire [`WORD_SIZE-1:0] i_d_addr,
	input wire                  i_data_done,
	input wire [`WORD_SIZE-1:0] i_num_inst,
	input wire                  i_halted
);
	int fail_count = 0;

	a_one_data_req: assert property (@(posedge clk) disable iff (reset_n)
		!(i_d_read && i_d_write))
	else begin
		fail_count++;
		$error("o_d_read and o_d_write high together");
	end

	// Fetch address held until the fetch completes or is redirected
	a_fetch_stable: assert property (@(posedge clk) disable iff (reset_n)
		(i_i_read && !i_fetch_done && !i_redirect) |=> $stable(i_i_addr))
	else begin
		fail_count++;
		$error("o_i_addr changed while a fetch was held");
	end

	a_data_stable: assert property (@(posedge clk) disable iff (reset_n)
		((i_d_read || i_d_write) && !i_data_done) |=> $stable(i_d_addr))
	else begin
		fail_count++;
		$error("o_d_addr changed while a data request was held");
	end

	a_halt_sticky: assert property (@(posedge clk) disable iff (reset_n)
		i_halted |=> i_halted)
	else begin
		fail_count++;
		$error("o_halted fell outside reset");
	end

	a_count_grows: assert property (@(posedge clk) disable iff (reset_n)
		1'b1 |=> (i_num_inst >= $past(i_num_inst)))
	else begin
		fail_count++;
		$error("o_num_inst decreased");
	end

endmodule

bind cpu_core cpu_checker chk_i (
	.clk          (clk),
	.reset_n      (reset_n),
	.i_i_read     (o_i_read),
	.i_i_addr     (o_i_addr),
	.i_fetch_done (i_done),
	.i_redirect   (redirect),
	.i_d_read     (o_d_read),
	.i_d_write    (o_d_write),
	.i_d_addr     (o_d_addr),
	.i_data_done  (d_done),
	.i_num_inst   (o_num_inst),
	.i_halted     (o_halted)
);

`default_nettype wire

//--- tb/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_params.svh"

module tb_cpu;
	import cpu_pkg::*;

	logic        clk;
	logic        reset_n;
	logic        i_read;
	logic [15:0] i_addr;
	logic [15:0] i_data;
	logic        d_read;
	logic        d_write;
	logic [15:0] d_addr;
	logic [15:0] d_wdata;
	logic [15:0] d_rdata;
	logic [15:0] num_inst;
	logic [15:0] out_port;
	logic        halted;

	logic [15:0] mem [256];
	logic [15:0] ref_mem [256];
	logic [15:0] exp_q [$];
	logic [15:0] last_port;
	int          prog_len;
	int          store_wait;

	cpu_core dut_i (
		.clk           (clk),
		.reset_n       (reset_n),
		.o_i_read      (i_read),
		.o_i_addr      (i_addr),
		.i_i_data      (i_data),
		.o_d_read      (d_read),
		.o_d_write     (d_write),
		.o_d_addr      (d_addr),
		.o_d_wdata     (d_wdata),
		.i_d_rdata     (d_rdata),
		.o_num_inst    (num_inst),
		.o_output_port (out_port),
		.o_halted      (halted)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// 256-word memory decodes the low address byte on both ports
	// Data only while a read is requested
	always @(posedge clk) begin
		#1;
		i_data  <= (i_read === 1'b1) ? mem[i_addr[7:0]] : 'x;
		d_rdata <= (d_read === 1'b1) ? mem[d_addr[7:0]] : 'x;
	end

	always @(negedge clk) begin
		if (d_write === 1'b1) begin
			store_wait = store_wait + 1;
			if (store_wait == `MEM_LATENCY) begin
				mem[d_addr[7:0]] = d_wdata;
				store_wait = 0;
			end
		end else begin
			store_wait = 0;
		end
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check(input string name, input logic [15:0] got, input logic [15:0] want);
		if (got !== want)
			report_failure($sformatf("CHECK FAILED at %0d ns: %s = 0x%h, expected 0x%h",
				$time, name, got, want));
	endtask

	function automatic logic [15:0] r_type(input func_e fn, input logic [1:0] rs,
			input logic [1:0] rt, input logic [1:0] rd);
		return {OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] i_type(input opcode_e op, input logic [1:0] rs,
			input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic emit(input logic [15:0] word);
		mem[prog_len] = word;
		prog_len++;
	endtask

	task automatic load_program();
		int         pick;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		for (int a = 0; a < 256; a++)
			mem[a] = {a[7:0] ^ 8'h5a, ~a[7:0]};
		prog_len = 0;
		// Dependencies at distance one, two and three
		emit(i_type(OP_ADI, 2'd0, 2'd1, 8'd5));
		emit(i_type(OP_ADI, 2'd1, 2'd2, 8'd3));
		emit(r_type(FN_ADD, 2'd1, 2'd2, 2'd3));
		emit(r_type(FN_SUB, 2'd1, 2'd3, 2'd0));
		emit(r_type(FN_WWD, 2'd0, 2'd0, 2'd0));
		emit(r_type(FN_AND, 2'd3, 2'd0, 2'd0));
		emit(r_type(FN_ORR, 2'd0, 2'd3, 2'd1));
		emit(r_type(FN_WWD, 2'd1, 2'd0, 2'd0));
		emit(r_type(FN_WWD, 2'd0, 2'd0, 2'd0));
		// Base 0xC0 in r2, then load-use and store-load
		emit(r_type(FN_SUB, 2'd2, 2'd2, 2'd2));
		emit(i_type(OP_ADI, 2'd2, 2'd2, 8'h60));
		emit(i_type(OP_ADI, 2'd2, 2'd2, 8'h60));
		emit(i_type(OP_LWD, 2'd2, 2'd3, 8'd4));
		emit(r_type(FN_WWD, 2'd3, 2'd0, 2'd0));
		emit(r_type(FN_ADD, 2'd3, 2'd3, 2'd1));
		emit(i_type(OP_SWD, 2'd2, 2'd1, 8'd9));
		emit(i_type(OP_LWD, 2'd2, 2'd0, 8'd9));
		emit(r_type(FN_WWD, 2'd0, 2'd0, 2'd0));
		// Taken BEQ, not-taken BNE and BEQ, taken BNE, then JMP
		emit(i_type(OP_BEQ, 2'd0, 2'd1, 8'd2));
		emit(r_type(FN_WWD, 2'd2, 2'd0, 2'd0));
		emit(i_type(OP_ADI, 2'd3, 2'd3, 8'd1));
		emit(i_type(OP_BNE, 2'd0, 2'd1, 8'd5));
		emit(r_type(FN_WWD, 2'd2, 2'd0, 2'd0));
		emit(i_type(OP_BEQ, 2'd2, 2'd3, 8'd3));
		emit(i_type(OP_BNE, 2'd2, 2'd3, 8'd1));
		emit(r_type(FN_WWD, 2'd3, 2'd0, 2'd0));
		emit({OP_JMP, 12'd29});
		emit(r_type(FN_WWD, 2'd1, 2'd0, 2'd0));
		emit(r_type(FN_HLT, 2'd0, 2'd0, 2'd0));
		for (int n = 0; n < 40; n++) begin
			pick = $urandom_range(4, 0);
			rs   = 2'($urandom);
			rt   = 2'($urandom);
			rd   = 2'($urandom);
			case (pick)
				0: emit(r_type(FN_ADD, rs, rt, rd));
				1: emit(r_type(FN_SUB, rs, rt, rd));
				2: emit(r_type(FN_AND, rs, rt, rd));
				3: emit(r_type(FN_ORR, rs, rt, rd));
				default: emit(i_type(OP_ADI, rs, rt, 8'($urandom)));
			endcase
		end
		for (int r = 0; r < 4; r++)
			emit(r_type(FN_WWD, 2'(r), 2'd0, 2'd0));
		emit(r_type(FN_HLT, 2'd0, 2'd0, 2'd0));
	endtask

	// Instruction-level model returning the retired count or -1 without HLT
	function automatic int interpret();
		logic [15:0] r [4];
		logic [15:0] pc;
		logic [15:0] ins;
		logic [15:0] imm;
		logic [15:0] next;
		logic [15:0] port;
		int          count;
		for (int a = 0; a < 256; a++)
			ref_mem[a] = mem[a];
		exp_q.delete();
		for (int i = 0; i < 4; i++)
			r[i] = '0;
		pc    = '0;
		port  = '0;
		count = 0;
		for (int step = 0; step < 2000; step++) begin
			ins   = ref_mem[pc[7:0]];
			imm   = {{8{ins[7]}}, ins[7:0]};
			next  = pc + 16'd1;
			count = count + 1;
			case (ins[15:12])
				OP_ADI: r[ins[9:8]] = r[ins[11:10]] + imm;
				OP_LWD: r[ins[9:8]] = ref_mem[8'(r[ins[11:10]] + imm)];
				OP_SWD: ref_mem[8'(r[ins[11:10]] + imm)] = r[ins[9:8]];
				OP_BEQ: if (r[ins[11:10]] == r[ins[9:8]]) next = pc + 16'd1 + imm;
				OP_BNE: if (r[ins[11:10]] != r[ins[9:8]]) next = pc + 16'd1 + imm;
				OP_JMP: next = {pc[15:12], ins[11:0]};
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADD: r[ins[7:6]] = r[ins[11:10]] + r[ins[9:8]];
						FN_SUB: r[ins[7:6]] = r[ins[11:10]] - r[ins[9:8]];
						FN_AND: r[ins[7:6]] = r[ins[11:10]] & r[ins[9:8]];
						FN_ORR: r[ins[7:6]] = r[ins[11:10]] | r[ins[9:8]];
						FN_WWD: begin
							// The port only shows a change of value
							if (r[ins[11:10]] != port)
								exp_q.push_back(r[ins[11:10]]);
							port = r[ins[11:10]];
						end
						FN_HLT: return count;
						default: count = count - 1;
					endcase
				end
				default: count = count - 1;
			endcase
			pc = next;
		end
		return -1;
	endfunction

	// Output port compare
	initial begin
		last_port = '0;
		forever begin
			@(negedge clk);
			if (reset_n === 1'b0 && out_port !== last_port) begin
				if (exp_q.size() == 0)
					report_failure("o_output_port changed with no value left to expect");
				check("o_output_port", out_port, exp_q.pop_front());
				last_port = out_port;
			end
		end
	end

	initial begin
		int exp_count;
		int cycles;
		void'($urandom(24368));
		reset_n    = 1'b1;
		i_data     = '0;
		d_rdata    = '0;
		store_wait = 0;
		load_program();
		exp_count = interpret();
		if (exp_count < 0)
			report_failure("Reference model reached its step limit without HLT");
		repeat (3) @(posedge clk);
		#1 reset_n = 1'b0;
		cycles = 0;
		while (halted !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (cycles > 4000)
				report_failure("Timeout waiting for o_halted");
		end
		check("o_num_inst", num_inst, exp_count[15:0]);
		repeat (20) begin
			@(negedge clk);
			check("o_halted", {15'd0, halted}, 16'd1);
			check("o_i_read", {15'd0, i_read}, 16'd0);
		end
		if (exp_q.size() != 0)
			report_failure($sformatf("%0d expected output port values never appeared",
				exp_q.size()));
		for (int a = 0; a < 256; a++)
			check($sformatf("mem[%0d]", a), mem[a], ref_mem[a]);
		if (dut_i.chk_i.fail_count == 0) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("RESULT: FAIL");
			$fatal(1, "%0d assertion failures in the checker", dut_i.chk_i.fail_count);
		end
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+design
design/cpu_pkg.sv
design/control_unit.sv
design/register_file.sv
design/alu.sv
design/hazard_forward.sv
design/cpu_core.sv
tb/cpu_checker.sv
tb/tb_cpu.sv
